/* Makefile */
.PHONY: compile run clean

# build the simulation executable with assertions enabled
compile:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		--top-module cpu_tb -f build.f -Mdir obj_dir -o simv

# the pass line in the log decides the result
run: compile
	obj_dir/simv | tee sim.log
	grep -qxF '>>> PASS' sim.log

clean:
	rm -rf obj_dir sim.log

/* build.f */
+incdir+verilog
verilog/isaPkg.sv
verilog/pipePkg.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/writebackStage.sv
verilog/cpu.sv
test/cpu_check.sv
test/cpu_assert.sv
test/cpu_tb.sv

/* test/cpu_assert.sv */
`timescale 1ns/1ps

module cpu_assert
	import isaPkg::*;
(
	input logic   clk,
	input logic   arstN,
	input pcT     pc,
	input logic   hlt,
	input logic   wbValid,
	input regIdxT wbAddr
);
	int failures = 0; // failed assertion count

	// writes to r0 are dropped before they retire
	noZeroWrite: assert property (@(posedge clk) disable iff (!arstN) wbValid |-> wbAddr != '0)
		else begin
			failures++;
			$error("retired write to r0");
		end

	hltSticky: assert property (@(posedge clk) disable iff (!arstN) hlt |=> hlt)
		else begin
			failures++;
			$error("hlt fell before reset"); // only reset may clear it
		end

	pcFrozen: assert property (@(posedge clk) disable iff (!arstN) hlt |=> $stable(pc))
		else begin
			failures++;
			$error("pc moved while halted");
		end
endmodule

bind cpu cpu_assert u_assert (.clk, .arstN, .pc, .hlt, .wbValid, .wbAddr);

/* test/cpu_check.sv */
`timescale 1ns/1ps

module cpu_check
	import isaPkg::*;
(
	input logic   clk,
	input logic   arstN,
	input pcT     pc,
	input logic   wbValid, // retire trace of the DUT
	input regIdxT wbAddr,
	input dataT   wbData
);
	regIdxT expAddr [$]; // pending writes, oldest first
	dataT   expData [$];
	regIdxT nextAddr;
	dataT   nextData;
	string  testName = "none";
	int     testErrors = 0;
	int     compared = 0;
	int     testsRun = 0;
	int     testsFailed = 0;
	int     errorCount = 0; // summed over every test

	function automatic void startTest(input string name);
		testName   = name;
		testErrors = 0;
		compared   = 0;
		expAddr.delete();
		expData.delete();
	endfunction

	function automatic void expectWrite(input regIdxT addr, input dataT data);
		expAddr.push_back(addr);
		expData.push_back(data);
	endfunction

	function automatic void reportProblem(input string what);
		$display("%s: %s", testName, what);
		testErrors++;
	endfunction

	// a halted pc keeps pointing at the HLT
	function automatic void checkHaltPc(input pcT expPc);
		if (pc != expPc) begin
			$display("Fail %s: expected pc = %h, actual pc = %h", testName, expPc, pc);
			testErrors++;
		end
	endfunction

	// trace settles after the rising edge, so look in mid cycle
	always @(negedge clk) begin
		if (arstN && wbValid) begin
			if (expAddr.size() == 0) begin
				reportProblem($sformatf("write to r%0d after the last expected write", wbAddr));
			end else begin
				nextAddr = expAddr.pop_front();
				nextData = expData.pop_front();
				compared++;
				if (wbAddr != nextAddr || wbData != nextData) begin
					$display("Fail %s: expected r%0d = %h, actual r%0d = %h",
						testName, nextAddr, nextData, wbAddr, wbData);
					testErrors++;
				end
			end
		end
	end

	function automatic void closeTest();
		if (expAddr.size() != 0)
			reportProblem($sformatf("%0d expected writes never retired", expAddr.size()));
		testsRun++;
		if (testErrors != 0) testsFailed++;
		errorCount += testErrors;
		$display("test %s %s, %0d writes compared", testName,
			testErrors == 0 ? "passed" : "failed", compared);
	endfunction

	function automatic void printSummary();
		$display("tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errorCount);
	endfunction
endmodule

/* test/cpu_tb.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpu_tb
	import isaPkg::*;
();
	logic   clk = 1'b0;
	logic   arstN;
	logic   imemWe;
	pcT     imemAddr;
	dataT   imemData;
	pcT     pc;
	logic   hlt;
	logic   wbValid;
	regIdxT wbAddr;
	dataT   wbData;
	logic   timedOut;

	// three programs back to back, each ends in HLT
	dataT progs [43] = '{
		// alu: 0x7fff and 1, overflowing add and sub, xor, shifts, write to r0
		16'hA1FF, 16'hB17F, 16'hA201, 16'h0312, 16'h1431, 16'h2534,
		16'h3614, 16'h4762, 16'h481F, 16'h0012, 16'hF000,
		// memory: stores fed by the previous instruction, loads behind a spacer
		16'hA110, 16'hA234, 16'hB212, 16'h9210, 16'h0322, 16'h9311,
		16'h8410, 16'h0911, 16'h8511, 16'h2719, 16'h1654, 16'h8811,
		16'h9812, 16'h2A11, 16'h8B12, 16'hF000, // load straight into a store
		// branch: eq taken, ne not, lt taken, gt not, ovf taken
		16'hA105, 16'hA205, 16'h1312, 16'hC201, 16'hA4AA, 16'hC001,
		16'h1601, 16'hC601, 16'hA722, 16'hC401, 16'hA833, 16'hB980,
		16'h1A91, 16'hCC01, 16'hAB44, 16'hF000
	};

	cpu u_dut (
		.clk, .arstN, .imemWe, .imemAddr, .imemData,
		.pc, .hlt, .wbValid, .wbAddr, .wbData
	);

	cpu_check u_check (.clk, .arstN, .pc, .wbValid, .wbAddr, .wbData);

	always #4 clk = ~clk; // 8 ns period

	// instruction-level model, fills the checker's list of expected writes
	function automatic void runModel(input int base, input int len, output pcT haltPc);
		dataT       regs [`REG_CNT];
		dataT       mem [`DMEM_DEPTH];
		dataT       w, a, res;
		opcodeT     op;
		logic [3:0] rd, rs, rt;
		logic       z, n, v, writes, take, halted;
		int         idx, steps, sa, sb, wide, ea;

		foreach (regs[i]) regs[i] = '0;
		foreach (mem[i]) mem[i] = '0;
		{z, n, v} = 3'b000;
		idx    = 0;
		steps  = 0;
		halted = 1'b0;
		haltPc = '0;
		while (!halted && idx >= 0 && idx < len && steps < 200) begin
			w      = progs[base + idx];
			op     = opcodeT'(w[15:12]);
			rd     = w[11:8];
			rs     = w[7:4];
			rt     = w[3:0];
			a      = regs[rs]; // r0 is never written, reads zero
			sa     = $signed(a);
			sb     = $signed(regs[rt]);
			ea     = int'(a) + 2 * int'($signed(rt)); // word offset to bytes
			writes = 1'b1;
			res    = '0;
			idx++;
			steps++;
			case (op)
				opAdd, opSub: begin
					wide = (op == opAdd) ? sa + sb : sa - sb;
					res  = wide[15:0]; // wraps
					v    = wide > 32767 || wide < -32768; // left the signed range
					n    = res[15];
					z    = res == '0;
				end
				opXor: begin
					res = a ^ regs[rt];
					z   = res == '0;
				end
				opSll, opSra: begin
					res = a;
					for (int k = 0; k < int'(rt); k++)
						res = (op == opSll) ? {res[14:0], 1'b0} : {res[15], res[15:1]};
					z = res == '0;
				end
				opLw: res = mem[ea[8:1]];
				opSw: begin
					mem[ea[8:1]] = regs[rd];
					writes       = 1'b0;
				end
				opLlb: res = {regs[rd][15:8], w[7:0]};
				opLhb: res = {w[7:0], regs[rd][7:0]};
				opB: begin
					case (w[11:9])
						3'd0:    take = !z; // ne
						3'd1:    take = z;
						3'd2:    take = !z && !n; // gt
						3'd3:    take = n;
						3'd4:    take = z || !n; // ge
						3'd5:    take = z || n;
						3'd6:    take = v;
						default: take = 1'b1;
					endcase
					if (take) idx += int'($signed(w[8:0])); // relative to next word
					writes = 1'b0;
				end
				opHlt: begin
					halted = 1'b1;
					haltPc = pcT'(2 * (idx - 1)); // idx already moved past the HLT
					writes = 1'b0;
				end
				default: writes = 1'b0; // unused codes do nothing
			endcase
			if (writes && rd != 4'd0) begin
				regs[rd] = res;
				u_check.expectWrite(rd, res);
			end
		end
	endfunction

	// load one program under reset, run it to HLT and close the test
	task automatic testProgram(input string name, input int base, input int len);
		int cycles;
		pcT haltPc;

		arstN = 1'b0;
		u_check.startTest(name);
		runModel(base, len, haltPc);
		for (int i = 0; i < 16; i++) begin
			imemWe   = i < len;
			imemAddr = pcT'(2 * i);
			if (i < len) imemData = progs[base + i];
			@(negedge clk);
		end
		imemWe = 1'b0;
		arstN  = 1'b1;
		cycles = 0;
		while (!hlt && cycles < 300) begin
			@(negedge clk);
			cycles++;
		end
		if (!hlt) begin
			$display("%s: timed out, hlt never rose", name);
			timedOut = 1'b1;
		end else begin
			repeat (4) @(negedge clk); // hlt must hold
			if (!hlt) u_check.reportProblem("hlt fell after it rose");
			u_check.checkHaltPc(haltPc);
			u_check.closeTest();
		end
	endtask

	initial begin
		arstN    = 1'b0;
		imemWe   = 1'b0;
		imemAddr = '0;
		imemData = '0;
		timedOut = 1'b0;
		testProgram("alu", 0, 11);
		if (!timedOut) testProgram("memory", 11, 16);
		if (!timedOut) testProgram("branch", 27, 16);
		u_check.printSummary();
		if (timedOut || u_check.errorCount != 0 || u_dut.u_assert.failures != 0) begin
			$display(">>> FAIL");
		end else begin
			$display(">>> PASS");
		end
		$finish;
	end
endmodule

/* verilog/cpu.sv */
`timescale 1ns/1ps

module cpu
	import isaPkg::*, pipePkg::*;
(
	input  logic   clk,
	input  logic   arstN,
	input  logic   imemWe,
	input  pcT     imemAddr,
	input  dataT   imemData,
	output pcT     pc,
	output logic   hlt,
	output logic   wbValid, // retire trace
	output regIdxT wbAddr,
	output dataT   wbData
);
	ifIdT   ifId;
	idExT   idEx;
	exMemT  exMem;
	flagsT  exFlags, exFlagsChange;
	logic   branchTaken;
	pcT     branchTarget;
	logic   memFwdValid;
	regIdxT memFwdAddr;
	dataT   memFwdData;

	fetchStage u_fetch (
		.clk, .arstN, .imemWe, .imemAddr, .imemData,
		.branchTaken, .branchTarget, .pc, .ifId
	);

	decodeStage u_decode (
		.clk, .arstN, .ifId, .exFlags, .exFlagsChange,
		.wbValid, .wbAddr, .wbData, .idEx, .branchTaken, .branchTarget
	);

	executeStage u_execute (
		.clk, .arstN, .idEx, .memFwdValid, .memFwdAddr, .memFwdData,
		.wbValid, .wbAddr, .wbData, .exMem, .exFlags, .exFlagsChange
	);

	writebackStage u_writeback (
		.clk, .arstN, .exMem, .memFwdValid, .memFwdAddr, .memFwdData,
		.wbValid, .wbAddr, .wbData, .hlt
	);
endmodule

/* verilog/cpu_defines.svh */
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// machine word width in bits
`define DATA_W 16

// architectural register count
`define REG_CNT 16

// memory depths in 16-bit words
`define IMEM_DEPTH 256
`define DMEM_DEPTH 256

`endif

/* verilog/decodeStage.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module decodeStage
	import isaPkg::*, pipePkg::*;
(
	input  logic   clk,
	input  logic   arstN,
	input  ifIdT   ifId,
	input  flagsT  exFlags, // flags being produced in execute right now
	input  flagsT  exFlagsChange,
	input  logic   wbValid,
	input  regIdxT wbAddr,
	input  dataT   wbData,
	output idExT   idEx,
	output logic   branchTaken,
	output pcT     branchTarget
);
	opcodeT op;
	regIdxT rd, rs, rt;
	condT   cond;
	dataT   regs [`REG_CNT];
	flagsT  flagQ, flagCur;
	logic   condMet;
	idExT   idExNext;

	assign op   = opcodeT'(ifId.instr[15:12]);
	assign rd   = ifId.instr[11:8];
	assign rs   = ifId.instr[7:4];
	assign rt   = ifId.instr[3:0];
	assign cond = condT'(ifId.instr[11:9]);

	// r0 reads zero and a same-cycle writeback passes straight through
	function automatic dataT readReg(regIdxT idx);
		if (idx == '0) return '0;
		if (wbValid && wbAddr == idx) return wbData;
		return regs[idx];
	endfunction

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < `REG_CNT; i++) regs[i] <= '0;
		end else if (wbValid) begin
			regs[wbAddr] <= wbData;
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			flagQ <= '0;
		end else begin
			if (exFlagsChange.z) flagQ.z <= exFlags.z; // each flag has its own enable
			if (exFlagsChange.n) flagQ.n <= exFlags.n;
			if (exFlagsChange.v) flagQ.v <= exFlags.v;
		end
	end

	assign flagCur.z = exFlagsChange.z ? exFlags.z : flagQ.z; // bypass from execute
	assign flagCur.n = exFlagsChange.n ? exFlags.n : flagQ.n;
	assign flagCur.v = exFlagsChange.v ? exFlags.v : flagQ.v;

	always_comb begin
		case (cond)
			condNe:  condMet = !flagCur.z;
			condEq:  condMet = flagCur.z;
			condGt:  condMet = !flagCur.z && !flagCur.n;
			condLt:  condMet = flagCur.n;
			condGe:  condMet = flagCur.z || !flagCur.n;
			condLe:  condMet = flagCur.z || flagCur.n;
			condOvf: condMet = flagCur.v;
			default: condMet = 1'b1; // always
		endcase
	end

	assign branchTaken  = ifId.valid && op == opB && condMet;
	assign branchTarget = ifId.pcPlus2 + {{(`DATA_W-10){ifId.instr[8]}}, ifId.instr[8:0], 1'b0};

	always_comb begin
		idExNext       = '0;
		idExNext.op    = op;
		idExNext.dest  = rd;
		idExNext.srcA  = rs;
		idExNext.srcB  = rt;
		idExNext.shamt = rt; // shifts take rt as a distance
		idExNext.valid = ifId.valid;
		case (op)
			opAdd, opSub, opXor, opSll, opSra: idExNext.we = 1'b1;
			opLw: begin
				idExNext.we      = 1'b1;
				idExNext.memRead = 1'b1;
				idExNext.imm     = {{(`DATA_W-5){rt[3]}}, rt, 1'b0}; // word offset
			end
			opSw: begin
				idExNext.memWrite = 1'b1;
				idExNext.srcB     = rd; // rd holds the data to store
				idExNext.imm      = {{(`DATA_W-5){rt[3]}}, rt, 1'b0};
			end
			opLlb, opLhb: begin
				idExNext.we   = 1'b1;
				idExNext.srcA = rd; // merge keeps the other byte of rd
				idExNext.imm  = {{(`DATA_W-8){1'b0}}, ifId.instr[7:0]};
			end
			default: ; // branch, halt and unused codes write nothing
		endcase
		idExNext.we   = idExNext.we && rd != '0; // writes to r0 vanish here
		idExNext.valA = readReg(idExNext.srcA);
		idExNext.valB = readReg(idExNext.srcB);
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) idEx <= '0;
		else        idEx <= idExNext;
	end
endmodule

/* verilog/executeStage.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module executeStage
	import isaPkg::*, pipePkg::*;
(
	input  logic   clk,
	input  logic   arstN,
	input  idExT   idEx,
	input  logic   memFwdValid, // alu result sitting in the memory stage
	input  regIdxT memFwdAddr,
	input  dataT   memFwdData,
	input  logic   wbValid,
	input  regIdxT wbAddr,
	input  dataT   wbData,
	output exMemT  exMem,
	output flagsT  exFlags,
	output flagsT  exFlagsChange
);
	localparam int msb = `DATA_W - 1;

	dataT opA, opB, result;
	logic isAlu, isAddSub;

	// the younger producer in memory beats the one in writeback
	function automatic dataT pickOperand(regIdxT idx, dataT decoded);
		if (idx != '0 && memFwdValid && memFwdAddr == idx) return memFwdData;
		if (idx != '0 && wbValid && wbAddr == idx) return wbData;
		return decoded;
	endfunction

	always_comb begin
		opA = pickOperand(idEx.srcA, idEx.valA);
		opB = pickOperand(idEx.srcB, idEx.valB);
	end

	always_comb begin
		exFlags.v = 1'b0;
		case (idEx.op)
			opAdd: begin
				result    = opA + opB; // wraps on overflow
				exFlags.v = opA[msb] == opB[msb] && result[msb] != opA[msb];
			end
			opSub: begin
				result    = opA - opB;
				exFlags.v = opA[msb] != opB[msb] && result[msb] != opA[msb];
			end
			opXor:      result = opA ^ opB;
			opSll:      result = opA << idEx.shamt;
			opSra:      result = dataT'($signed(opA) >>> idEx.shamt);
			opLw, opSw: result = opA + idEx.imm; // effective address
			opLlb:      result = {opA[msb:8], idEx.imm[7:0]};
			opLhb:      result = {idEx.imm[7:0], opA[7:0]};
			default:    result = '0;
		endcase
		exFlags.z = result == '0;
		exFlags.n = result[msb];
	end

	assign isAddSub = idEx.op == opAdd || idEx.op == opSub;
	assign isAlu    = isAddSub || idEx.op == opXor || idEx.op == opSll || idEx.op == opSra;

	assign exFlagsChange.z = idEx.valid && isAlu;
	assign exFlagsChange.n = idEx.valid && isAddSub; // n and v only from add and sub
	assign exFlagsChange.v = idEx.valid && isAddSub;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			exMem <= '0;
		end else begin
			exMem.result    <= result;
			exMem.storeData <= opB;
			exMem.storeSrc  <= idEx.srcB;
			exMem.dest      <= idEx.dest;
			exMem.op        <= idEx.op;
			exMem.we        <= idEx.we;
			exMem.memRead   <= idEx.memRead;
			exMem.memWrite  <= idEx.memWrite;
			exMem.valid     <= idEx.valid;
		end
	end
endmodule

/* verilog/fetchStage.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module fetchStage
	import isaPkg::*, pipePkg::*;
(
	input  logic clk,
	input  logic arstN,
	input  logic imemWe, // program load strobe
	input  pcT   imemAddr,
	input  dataT imemData,
	input  logic branchTaken, // from decode
	input  pcT   branchTarget,
	output pcT   pc,
	output ifIdT ifId
);
	localparam int imemAw = $clog2(`IMEM_DEPTH);

	dataT imem [`IMEM_DEPTH]; // word organised, indexed by pc bits above bit 0
	dataT fetchWord;
	logic fetchHalt;
	pcT   pcNext;

	always_ff @(posedge clk) begin
		if (imemWe) imem[imemAddr[imemAw:1]] <= imemData; // loader port
	end

	assign fetchWord = imem[pc[imemAw:1]]; // combinational read
	assign fetchHalt = opcodeT'(fetchWord[15:12]) == opHlt;

	// branch beats halt so a flushed HLT releases the freeze
	assign pcNext = branchTaken ? branchTarget : fetchHalt ? pc : pc + pcT'(2);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc   <= '0;
			ifId <= '0;
		end else begin
			pc           <= pcNext;
			ifId.instr   <= fetchWord;
			ifId.pcPlus2 <= pc + pcT'(2);
			ifId.valid   <= !branchTaken; // squash the slot behind a taken branch
		end
	end
endmodule

/* verilog/isaPkg.sv */
`include "cpu_defines.svh"

package isaPkg;
	typedef logic [`DATA_W-1:0] dataT; // one machine word
	typedef logic [`DATA_W-1:0] pcT; // byte address, always even
	typedef logic [$clog2(`REG_CNT)-1:0] regIdxT; // register number
	typedef logic [3:0] shamtT; // shift distance from the rt field

	typedef enum logic [3:0] {
		opAdd = 4'h0,
		opSub = 4'h1,
		opXor = 4'h2,
		opSll = 4'h3,
		opSra = 4'h4,
		opLw  = 4'h8,
		opSw  = 4'h9,
		opLlb = 4'hA,
		opLhb = 4'hB,
		opB   = 4'hC,
		opHlt = 4'hF
	} opcodeT; // codes not listed here run as no-ops

	typedef enum logic [2:0] {
		condNe, condEq, condGt, condLt, condGe, condLe, condOvf, condAlways
	} condT; // ccc field of a branch

	typedef struct packed {
		logic z; // result was zero
		logic n; // result was negative
		logic v; // signed overflow
	} flagsT;
endpackage

/* verilog/pipePkg.sv */
package pipePkg;
	import isaPkg::*;

	typedef struct packed {
		dataT instr; // raw fetched word
		pcT   pcPlus2; // return point and branch base
		logic valid;
	} ifIdT;

	typedef struct packed {
		opcodeT op;
		regIdxT dest;
		regIdxT srcA; // rs, or rd for the byte loads
		regIdxT srcB; // rt, or rd for a store
		dataT   valA;
		dataT   valB;
		dataT   imm; // scaled offset or byte immediate
		shamtT  shamt;
		logic   we;
		logic   memRead;
		logic   memWrite;
		logic   valid;
	} idExT;

	typedef struct packed {
		dataT   result; // alu value or memory address
		dataT   storeData;
		regIdxT storeSrc; // lets writeback patch store data late
		regIdxT dest;
		opcodeT op;
		logic   we;
		logic   memRead;
		logic   memWrite;
		logic   valid;
	} exMemT;

	typedef struct packed {
		dataT   value; // alu or merged byte result
		dataT   loadWord;
		regIdxT dest;
		logic   we;
		logic   memRead;
		logic   isHalt;
		logic   valid;
	} memWbT;
endpackage

/* verilog/writebackStage.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module writebackStage
	import isaPkg::*, pipePkg::*;
(
	input  logic   clk,
	input  logic   arstN,
	input  exMemT  exMem,
	output logic   memFwdValid,
	output regIdxT memFwdAddr,
	output dataT   memFwdData,
	output logic   wbValid,
	output regIdxT wbAddr,
	output dataT   wbData,
	output logic   hlt
);
	localparam int dmemAw = $clog2(`DMEM_DEPTH);

	dataT  dmem [`DMEM_DEPTH]; // no clear, programs store before loading
	dataT  storeData;
	memWbT memWb;
	logic  wbHalt, hltQ;

	// loads are not ready until writeback
	assign memFwdValid = exMem.valid && exMem.we && !exMem.memRead;
	assign memFwdAddr  = exMem.dest;
	assign memFwdData  = exMem.result;

	// store data produced by the instruction now retiring
	assign storeData = (wbValid && wbAddr == exMem.storeSrc) ? wbData : exMem.storeData;

	always_ff @(posedge clk) begin
		if (exMem.valid && exMem.memWrite) dmem[exMem.result[dmemAw:1]] <= storeData;
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			memWb <= '0;
		end else begin
			memWb.value    <= exMem.result;
			memWb.loadWord <= dmem[exMem.result[dmemAw:1]];
			memWb.dest     <= exMem.dest;
			memWb.we       <= exMem.we;
			memWb.memRead  <= exMem.memRead;
			memWb.isHalt   <= exMem.op == opHlt;
			memWb.valid    <= exMem.valid;
		end
	end

	assign wbValid = memWb.valid && memWb.we;
	assign wbAddr  = memWb.dest;
	assign wbData  = memWb.memRead ? memWb.loadWord : memWb.value;

	assign wbHalt = memWb.valid && memWb.isHalt;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)      hltQ <= 1'b0;
		else if (wbHalt) hltQ <= 1'b1; // sticky until reset
	end

	assign hlt = hltQ || wbHalt; // high in the cycle the HLT retires
endmodule
